/* logic/noc_pkg.sv */
package noc_pkg;

    //////////////////////////////////////////////////
    // network and packet geometry
    //////////////////////////////////////////////////

    localparam int NODE_COUNT   = 8;
    localparam int NODE_W       = $clog2(NODE_COUNT);
    localparam int ID_W         = 5;
    localparam int DATA_W       = 17;
    localparam int FRAG_COUNT   = 4;
    localparam int FRAG_W       = $clog2(FRAG_COUNT);
    localparam int PACKET_W     = DATA_W * FRAG_COUNT;   // fragment 0 holds the top bits

    localparam int SOURCE_COUNT = 4;
    localparam int SRC_W        = $clog2(SOURCE_COUNT);  // width of a splitter index

    //////////////////////////////////////////////////
    // flit layout, low bits first
    //////////////////////////////////////////////////

    localparam int FRAG_LSB  = 0;
    localparam int START_LSB = FRAG_LSB + FRAG_W;
    localparam int ID_LSB    = START_LSB + NODE_W;
    localparam int DATA_LSB  = ID_LSB + ID_W;
    localparam int DEST_LSB  = DATA_LSB + DATA_W;
    localparam int VALID_BIT = DEST_LSB + NODE_W;
    localparam int FLIT_W    = VALID_BIT + 1;           // 31 bits with the default widths

endpackage

/* logic/packet_splitter.sv */
`timescale 1ns/1ns

module packet_splitter
    import noc_pkg::*;
#(
    parameter int NODE_ID = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                send_valid,
    input  logic [PACKET_W-1:0] send_packet,
    input  logic [NODE_W-1:0]   send_dest,
    input  logic [ID_W-1:0]     send_id,
    input  logic                grant,
    output logic                busy,
    output logic                flit_req,
    output logic [FLIT_W-1:0]   flit
);

    logic                active;
    logic [FRAG_W-1:0]   frag_idx;
    logic                accept;
    logic                last_frag;

    logic [PACKET_W-1:0] packet_q;
    logic [NODE_W-1:0]   dest_q;
    logic [ID_W-1:0]     id_q;
    logic [DATA_W-1:0]   frag_data;

    assign accept    = send_valid && !active;                    // only sampled while idle
    assign last_frag = (frag_idx == FRAG_W'(FRAG_COUNT - 1));

    //////////////////////////////////////////////////
    // fragment sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            frag_idx <= '0;
        end else if (accept) begin
            active   <= 1'b1;
            frag_idx <= '0;
        end else if (active && grant) begin
            frag_idx <= frag_idx + 1'b1;
            if (last_frag) begin
                active <= 1'b0;                                  // idle again after the last flit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            packet_q <= send_packet;
            dest_q   <= send_dest;
            id_q     <= send_id;
        end
    end

    //////////////////////////////////////////////////
    // flit assembly
    //////////////////////////////////////////////////

    always_comb begin
        frag_data = packet_q[PACKET_W - 1 - DATA_W * int'(frag_idx) -: DATA_W];
    end

    always_comb begin
        flit                         = '0;
        flit[VALID_BIT]              = active;
        flit[DEST_LSB +: NODE_W]     = dest_q;
        flit[DATA_LSB +: DATA_W]     = frag_data;
        flit[ID_LSB +: ID_W]         = id_q;
        flit[START_LSB +: NODE_W]    = NODE_W'(NODE_ID);
        flit[FRAG_LSB +: FRAG_W]     = frag_idx;
    end

    assign busy     = active;
    assign flit_req = active;                                    // request stays up for all fragments

endmodule

/* logic/flit_arbiter.sv */
`timescale 1ns/1ns

module flit_arbiter
    import noc_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 ce,
    input  logic [SOURCE_COUNT-1:0]              req,
    input  logic [SOURCE_COUNT-1:0][FLIT_W-1:0]  flit_in,
    output logic [SOURCE_COUNT-1:0]              grant,
    output logic                                 merged_valid,
    output logic [FLIT_W-1:0]                    merged_flit
);

    logic [SRC_W-1:0] last_ptr;
    logic [SRC_W-1:0] grant_idx;
    logic             found;

    //////////////////////////////////////////////////
    // round-robin search
    //////////////////////////////////////////////////

    // the search starts one past the last granted source
    always_comb begin
        int idx;

        grant     = '0;
        grant_idx = last_ptr;
        found     = 1'b0;
        idx       = 0;
        if (ce) begin                                            // nothing is granted while ce is low
            for (int off = 1; off <= SOURCE_COUNT; off++) begin
                idx = (int'(last_ptr) + off) % SOURCE_COUNT;
                if (!found && req[idx]) begin
                    found     = 1'b1;
                    grant_idx = SRC_W'(idx);
                end
            end
        end
        if (found) begin
            grant[grant_idx] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // merged stream register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_ptr     <= SRC_W'(SOURCE_COUNT - 1);            // source 0 wins first
            merged_valid <= 1'b0;
            merged_flit  <= '0;
        end else if (ce) begin                                   // an in-flight flit is held while ce is low
            merged_valid <= found;
            merged_flit  <= {found, flit_in[grant_idx][VALID_BIT-1:0]};
            if (found) begin
                last_ptr <= grant_idx;                           // rotate only on a real grant
            end
        end
    end

endmodule

/* logic/packet_collector.sv */
`timescale 1ns/1ns

module packet_collector
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ce,
    input  logic [FLIT_W-1:0]   flit_in,
    output logic                valid_out,
    output logic [PACKET_W-1:0] packet_out,
    output logic [NODE_W-1:0]   node_start_out,
    output logic [NODE_W-1:0]   node_dest_out,
    output logic [ID_W-1:0]     packet_id_out
);

    // reassembly table
    logic [BUFFER_SIZE-1:0] valid_q;
    logic [DATA_W-1:0]      frag_q  [BUFFER_SIZE][FRAG_COUNT];
    logic [FRAG_COUNT-1:0]  mask_q  [BUFFER_SIZE];
    logic [31:0]            stamp_q [BUFFER_SIZE];
    logic [NODE_W-1:0]      start_q [BUFFER_SIZE];
    logic [NODE_W-1:0]      dest_q  [BUFFER_SIZE];
    logic [ID_W-1:0]        id_q    [BUFFER_SIZE];
    logic [31:0]            stamp_now;

    // incoming flit fields
    logic                   take;
    logic [FRAG_W-1:0]      f_frag;
    logic [NODE_W-1:0]      f_start;
    logic [ID_W-1:0]        f_id;
    logic [DATA_W-1:0]      f_data;
    logic [NODE_W-1:0]      f_dest;
    logic [FRAG_COUNT-1:0]  frag_bit;

    // lookup results
    logic                   hit;
    int                     tgt;
    logic [FRAG_COUNT-1:0]  new_mask;
    logic                   complete;
    logic [PACKET_W-1:0]    out_pkt;
    logic [NODE_W-1:0]      out_start;
    logic [NODE_W-1:0]      out_dest;
    logic [ID_W-1:0]        out_id;

    assign take    = ce && flit_in[VALID_BIT];                   // table is frozen while ce is low
    assign f_frag  = flit_in[FRAG_LSB +: FRAG_W];
    assign f_start = flit_in[START_LSB +: NODE_W];
    assign f_id    = flit_in[ID_LSB +: ID_W];
    assign f_data  = flit_in[DATA_LSB +: DATA_W];
    assign f_dest  = flit_in[DEST_LSB +: NODE_W];

    //////////////////////////////////////////////////
    // match, allocation and eviction
    //////////////////////////////////////////////////

    always_comb begin
        int          hit_idx;
        int          free_idx;
        int          victim_idx;
        int          cnt;
        int          min_cnt;
        logic        free_found;
        logic [31:0] min_stamp;

        hit        = 1'b0;
        hit_idx    = 0;
        free_found = 1'b0;
        free_idx   = 0;
        victim_idx = 0;
        cnt        = 0;
        min_cnt    = FRAG_COUNT + 1;
        min_stamp  = '1;
        for (int i = 0; i < BUFFER_SIZE; i++) begin
            if (valid_q[i] && start_q[i] == f_start && id_q[i] == f_id) begin
                hit     = 1'b1;
                hit_idx = i;
            end
            if (!valid_q[i] && !free_found) begin
                free_found = 1'b1;                               // lowest free entry wins
                free_idx   = i;
            end
        end
        // fewest fragments first, then the oldest stamp
        for (int i = 0; i < BUFFER_SIZE; i++) begin
            cnt = $countones(mask_q[i]);
            if (valid_q[i] && (cnt < min_cnt ||
                               (cnt == min_cnt && stamp_q[i] < min_stamp))) begin
                min_cnt    = cnt;
                min_stamp  = stamp_q[i];
                victim_idx = i;
            end
        end
        tgt = hit ? hit_idx : (free_found ? free_idx : victim_idx);

        frag_bit         = '0;
        frag_bit[f_frag] = 1'b1;
        new_mask = (hit ? mask_q[tgt] : '0) | frag_bit;
        complete = &new_mask;

        for (int k = 0; k < FRAG_COUNT; k++) begin
            out_pkt[PACKET_W - 1 - DATA_W * k -: DATA_W] =
                (k == int'(f_frag)) ? f_data : frag_q[tgt][k];
        end
        out_start = hit ? start_q[tgt] : f_start;
        out_dest  = hit ? dest_q[tgt]  : f_dest;
        out_id    = hit ? id_q[tgt]    : f_id;
    end

    //////////////////////////////////////////////////
    // table update and output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= '0;
            stamp_now <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= take && complete;                       // single-cycle pulse
            if (take) begin
                stamp_now    <= stamp_now + 1'b1;
                valid_q[tgt] <= !complete;                       // a finished packet frees its slot
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            frag_q[tgt][f_frag] <= f_data;
            mask_q[tgt]         <= new_mask;
            stamp_q[tgt]        <= stamp_now;
            if (!hit) begin
                start_q[tgt] <= f_start;
                dest_q[tgt]  <= f_dest;
                id_q[tgt]    <= f_id;
            end
            if (complete) begin
                packet_out     <= out_pkt;
                node_start_out <= out_start;
                node_dest_out  <= out_dest;
                packet_id_out  <= out_id;
            end
        end
    end

endmodule

/* logic/noc_sink_top.sv */
`timescale 1ns/1ns

module noc_sink_top
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 ce,
    input  logic [SOURCE_COUNT-1:0]              send_valid,
    input  logic [SOURCE_COUNT-1:0][PACKET_W-1:0] send_packet,
    input  logic [SOURCE_COUNT-1:0][NODE_W-1:0]  send_dest,
    input  logic [SOURCE_COUNT-1:0][ID_W-1:0]    send_id,
    output logic [SOURCE_COUNT-1:0]              busy,
    output logic                                 valid_out,
    output logic [PACKET_W-1:0]                  packet_out,
    output logic [NODE_W-1:0]                    node_start_out,
    output logic [NODE_W-1:0]                    node_dest_out,
    output logic [ID_W-1:0]                      packet_id_out
);

    logic [SOURCE_COUNT-1:0]             flit_req;
    logic [SOURCE_COUNT-1:0]             grant;
    logic [SOURCE_COUNT-1:0][FLIT_W-1:0] split_flit;
    logic                                merged_valid;
    logic [FLIT_W-1:0]                   merged_flit;
    logic [FLIT_W-1:0]                   collector_flit;

    //////////////////////////////////////////////////
    // source splitters, one per node 0 to 3
    //////////////////////////////////////////////////

    for (genvar s = 0; s < SOURCE_COUNT; s++) begin : g_src
        packet_splitter #(
            .NODE_ID     (s)
        ) splitter_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .send_valid  (send_valid[s]),
            .send_packet (send_packet[s]),
            .send_dest   (send_dest[s]),
            .send_id     (send_id[s]),
            .grant       (grant[s]),
            .busy        (busy[s]),
            .flit_req    (flit_req[s]),
            .flit        (split_flit[s])
        );
    end

    flit_arbiter arbiter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ce           (ce),
        .req          (flit_req),
        .flit_in      (split_flit),
        .grant        (grant),
        .merged_valid (merged_valid),
        .merged_flit  (merged_flit)
    );

    // the collector qualifies each flit by its own valid bit
    assign collector_flit = {merged_valid, merged_flit[VALID_BIT-1:0]};

    packet_collector #(
        .BUFFER_SIZE    (BUFFER_SIZE)
    ) collector_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ce             (ce),
        .flit_in        (collector_flit),
        .valid_out      (valid_out),
        .packet_out     (packet_out),
        .node_start_out (node_start_out),
        .node_dest_out  (node_dest_out),
        .packet_id_out  (packet_id_out)
    );

endmodule

/* bench/collector_tasks.svh */
//////////////////////////////////////////////////
// checking and failure reporting
//////////////////////////////////////////////////

task automatic abort_run(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic check_equal(input logic [PACKET_W-1:0] actual,
                           input logic [PACKET_W-1:0] expected,
                           input string msg);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                 $time, msg, actual, expected);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    end
endtask

//////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////

task automatic step();
    @(posedge clk);
    #1;                                                 // inputs change just after the edge
endtask

task automatic wait_idle(input logic [SOURCE_COUNT-1:0] mask);
    int n;
    n = 0;
    while ((busy & mask) != '0 && n < WAIT_LIMIT) begin
        step();
        n++;
    end
    if ((busy & mask) != '0) begin
        abort_run("timed out waiting for the splitters to become idle");
    end
endtask

task automatic load_packet(input int src);
    pkt_t p;
    p.cycle  = '0;
    p.packet = PACKET_W'({$random(seed), $random(seed), $random(seed)});
    p.dest   = NODE_W'($random(seed));
    p.id     = next_id;
    p.start  = NODE_W'(src);
    next_id++;                                          // keeps every node/id pair unique
    send_packet[src] = p.packet;
    send_dest[src]   = p.dest;
    send_id[src]     = p.id;
    send_valid[src]  = 1'b1;
    exp_q.push_back(p);
endtask

task automatic release_sends();
    step();
    send_valid = '0;                                    // splitters latched on that edge
endtask

//////////////////////////////////////////////////
// response side
//////////////////////////////////////////////////

task automatic wait_for_packet(output pkt_t rx);
    int n;
    n = 0;
    while (rx_q.size() == 0 && n < WAIT_LIMIT) begin
        step();
        n++;
    end
    if (rx_q.size() == 0) begin
        abort_run("timed out waiting for a completed packet on valid_out");
    end else begin
        rx = rx_q.pop_front();
    end
endtask

// a delivered packet must match an outstanding send, which is then retired
task automatic match_expected(input pkt_t rx);
    int hit;
    hit = -1;
    foreach (exp_q[i]) begin
        if (exp_q[i].start == rx.start && exp_q[i].id == rx.id) begin
            hit = i;
        end
    end
    if (hit < 0) begin
        abort_run($sformatf("packet from node %0d id %0d matches no outstanding send",
                            rx.start, rx.id));
    end else begin
        check_equal(rx.packet, exp_q[hit].packet, "packet data");
        check_equal(rx.dest, exp_q[hit].dest, "destination node");
        exp_q.delete(hit);
    end
endtask

/* bench/collector_tb.sv */
`timescale 1ns/1ns

module collector_tb
    import noc_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [31:0]         cycle;
        logic [ID_W-1:0]     id;
        logic [NODE_W-1:0]   dest;
        logic [NODE_W-1:0]   start;
        logic [PACKET_W-1:0] packet;
    } pkt_t;

    logic                                  clk = 1'b0;
    logic                                  rst_n;
    logic                                  ce;
    logic [SOURCE_COUNT-1:0]               send_valid;
    logic [SOURCE_COUNT-1:0][PACKET_W-1:0] send_packet;
    logic [SOURCE_COUNT-1:0][NODE_W-1:0]   send_dest;
    logic [SOURCE_COUNT-1:0][ID_W-1:0]     send_id;
    logic [SOURCE_COUNT-1:0]               busy;
    logic                                  valid_out;
    logic [PACKET_W-1:0]                   packet_out;
    logic [NODE_W-1:0]                     node_start_out;
    logic [NODE_W-1:0]                     node_dest_out;
    logic [ID_W-1:0]                       packet_id_out;

    int              seed;
    int              cycle_cnt = 0;
    logic [ID_W-1:0] next_id;
    pkt_t            rx_q[$];                           // everything seen on valid_out
    pkt_t            exp_q[$];                          // sent and not yet delivered

    `include "collector_tasks.svh"

    always #5 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // sample on the falling edge where the outputs are settled
    always @(negedge clk) begin
        pkt_t rx;
        if (rst_n && valid_out) begin
            rx.cycle  = cycle_cnt;
            rx.id     = packet_id_out;
            rx.dest   = node_dest_out;
            rx.start  = node_start_out;
            rx.packet = packet_out;
            rx_q.push_back(rx);
        end
    end

    noc_sink_top #(
        .BUFFER_SIZE    (2)                             // small table so eviction happens
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ce             (ce),
        .send_valid     (send_valid),
        .send_packet    (send_packet),
        .send_dest      (send_dest),
        .send_id        (send_id),
        .busy           (busy),
        .valid_out      (valid_out),
        .packet_out     (packet_out),
        .node_start_out (node_start_out),
        .node_dest_out  (node_dest_out),
        .packet_id_out  (packet_id_out)
    );

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_single_packet();
        pkt_t rx;
        int   t0;
        wait_idle(4'b0010);
        load_packet(1);
        t0 = cycle_cnt;
        release_sends();
        wait_for_packet(rx);
        match_expected(rx);
        check_equal(rx.start, 1, "start node of source 1");
        check_equal(rx.cycle - t0, 6, "latency from send to valid_out");
    endtask

    task automatic test_interleaved_pair();
        pkt_t rx;
        wait_idle(4'b0101);
        load_packet(0);
        load_packet(2);
        release_sends();
        repeat (2) begin
            wait_for_packet(rx);
            match_expected(rx);
        end
        repeat (3) step();
        check_equal(rx_q.size(), 0, "no duplicate of the interleaved packets");
    endtask

    task automatic test_ce_stretches();
        pkt_t rx;
        int   src;
        int   low;
        int   gap;
        repeat (10) begin
            src = $unsigned($random(seed)) % SOURCE_COUNT;
            low = 1 + $unsigned($random(seed)) % 5;
            gap = $unsigned($random(seed)) % 4;
            wait_idle('1);
            load_packet(src);
            release_sends();
            repeat (gap) step();                        // ce drops somewhere inside the packet
            ce = 1'b0;
            repeat (low) step();
            ce = 1'b1;
            wait_for_packet(rx);
            match_expected(rx);
        end
        repeat (3) step();
        check_equal(rx_q.size(), 0, "no duplicate delivery across ce gaps");
    endtask

    task automatic test_overload();
        pkt_t rx;
        wait_idle('1);
        for (int s = 0; s < SOURCE_COUNT; s++) begin
            load_packet(s);
        end
        release_sends();
        wait_idle('1);
        repeat (3) step();                              // last flit drains two edges after busy
        while (rx_q.size() > 0) begin
            rx = rx_q.pop_front();
            match_expected(rx);
        end
        exp_q.delete();                                 // evicted packets never arrive
        load_packet(3);
        release_sends();
        wait_for_packet(rx);
        match_expected(rx);
        check_equal(rx.start, 3, "start node of the packet after overload");
    endtask

    initial begin
        seed        = 32'hb67fb3c9;
        rst_n       = 1'b0;
        ce          = 1'b0;
        send_valid  = '0;
        send_packet = '0;
        send_dest   = '0;
        send_id     = '0;
        next_id     = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        ce    = 1'b1;

        check_equal(valid_out, 0, "valid_out after reset");
        check_equal(busy, 0, "busy after reset");
        test_single_packet();
        test_interleaved_pair();
        test_ce_stretches();
        test_overload();
        repeat (3) step();
        check_equal(rx_q.size(), 0, "no extra packets on valid_out");

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+bench
logic/noc_pkg.sv
logic/packet_splitter.sv
logic/flit_arbiter.sv
logic/packet_collector.sv
logic/noc_sink_top.sv
bench/collector_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module collector_tb \
    -f list.f \
    -o collector_sim

./obj_dir/collector_sim 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "collector simulation passed"
else
    echo "collector simulation failed"
    exit 1
fi
